// ==== testbench/cpu_vectors.txt ====
# P <word>: program word, loaded in order from address 0; text after # is ignored
# W <reg> <data>: expected register write; M <address> <data>: expected store
P 2105   # ldr r1, 05
W 1 0005
P 22F0   # ldr r2, f0
W 2 00F0
P 2300   # ldr r3, 00
W 3 0000
P E000   # nop
P 3410   # mov r4, r1
W 4 0005
P A512   # add r5, r1, r2
W 5 00F5
P B631   # sub r6, r3, r1
W 6 FFFB
P 6712   # xor r7, r1, r2
W 7 00F5
P 4821   # and r8, r2, r1
W 8 0000
P 7960   # not r9, r6
W 9 0004
P 9A6B   # shr arithmetic r10, r6, 3
W A FFFF
P 9B67   # shr logical r11, r6, 7
W B 01FF
P 8C57   # shl r12, r5, 7
W C 7A80
P 1610   # stm r6 to 10
M 10 FFFB
P C123   # old div class
P D456   # old div class
P 0D10   # ldm r13 from 10
W D FFFB
P 8E18   # shl arithmetic r14, r1, 0
W E 0005
P 9FC8   # shr arithmetic r15, r12, 0
W F 7A80
P A16C   # add r1, r6, r12
W 1 7A7B
P 529C   # or r2, r9, r12
W 2 7A84
P F000   # halt

// ==== compile.f ====
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_control.sv
src/register_file.sv
src/data_memory.sv
src/execute_unit.sv
src/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

// ==== testbench/cpu_tb.sv ====
// testbench for cpu_top: vector file loading, program load, write-event checks, watchdog
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	localparam int imem_addr_width = 8;             // full 256-word program space
	localparam int clock_period = 40;               // ns

	logic clock;
	logic reset;
	logic load_en;
	logic [imem_addr_width-1:0] load_addr;
	word_t load_data;
	logic reg_write;
	reg_addr_t reg_write_address;
	word_t reg_write_data;
	logic mem_write;
	mem_addr_t mem_write_address;
	word_t mem_write_data;
	logic zero_flag;
	logic negative_flag;
	logic halted;

	word_t program_words [$];                       // P lines
	logic [23:0] expected_regs [$];                 // W lines as {reg, data}
	logic [23:0] expected_stores [$];               // M lines as {address, data}
	int reg_count;
	int store_count;
	logic run_started;                              // reset released

	cpu_top #(.imem_addr_width(imem_addr_width)) u_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	task automatic report_failure(input string what);
	begin
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "run stopped");
	end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	begin
		if (expected !== actual)
			report_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	end
	endtask

	task automatic load_vectors();
		int fd;
		int fields;
		string line;
		logic [15:0] field_a;
		logic [15:0] field_b;
	begin
		fd = $fopen("testbench/cpu_vectors.txt", "r");
		if (fd == 0)
			report_failure("cannot open testbench/cpu_vectors.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1)                 // skip blank lines
				begin
					fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", field_a, field_b);
					if ((line[0] == "P" && fields < 1) ||
						((line[0] == "W" || line[0] == "M") && fields < 2))
						report_failure({"malformed vector line ", line});
					else if (line[0] == "P")
						program_words.push_back(field_a);
					else if (line[0] == "W")
						expected_regs.push_back({field_a[7:0], field_b});
					else if (line[0] == "M")
						expected_stores.push_back({field_a[7:0], field_b});
				end
			end
			$fclose(fd);
		end
	end
	endtask

	task automatic check_register_write();
		logic [23:0] expected;
		string name;
	begin
		if (expected_regs.size() == 0)
			report_failure("register write seen with no expected write left");
		else
		begin
			expected = expected_regs.pop_front();
			name = $sformatf("register write %0d", reg_count);
			check_value({name, " address"}, 32'(expected[19:16]), 32'(reg_write_address));
			check_value({name, " data"}, 32'(expected[15:0]), 32'(reg_write_data));
			// flags follow the written value
			check_value({name, " zero flag"}, 32'(expected[15:0] == 16'h0), 32'(zero_flag));
			check_value({name, " negative flag"}, 32'(expected[15]), 32'(negative_flag));
			reg_count++;
		end
	end
	endtask

	task automatic check_store();
		logic [23:0] expected;
		string name;
	begin
		if (expected_stores.size() == 0)
			report_failure("store seen with no expected store left");
		else
		begin
			expected = expected_stores.pop_front();
			name = $sformatf("store %0d", store_count);
			check_value({name, " address"}, 32'(expected[23:16]), 32'(mem_write_address));
			check_value({name, " data"}, 32'(expected[15:0]), 32'(mem_write_data));
			store_count++;
		end
	end
	endtask

	// outputs settle after the rising edge, sample at the falling one
	always @(negedge clock)
	begin
		if (reset === 1'b1 && (reg_write === 1'b1 || mem_write === 1'b1))
			report_failure("a write strobe was high during reset");
		else if (reset === 1'b0)
		begin
			if (reg_write === 1'b1)
				check_register_write();
			if (mem_write === 1'b1)
				check_store();
		end
	end

	initial
	begin
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		reg_count = 0;
		store_count = 0;
		run_started = 1'b0;
		load_vectors();
		if (program_words.size() == 0 || program_words.size() > 2**imem_addr_width)
			report_failure("program in the vector file is empty or too long");
		foreach (program_words[i])                  // one word per edge, under reset
		begin
			@(posedge clock);
			#2;
			load_en = 1'b1;
			load_addr = imem_addr_width'(i);
			load_data = program_words[i];
		end
		@(posedge clock);
		#2;
		load_en = 1'b0;
		repeat (10) @(posedge clock);               // ten more reset cycles
		#2;
		reset = 1'b0;
		run_started = 1'b1;
		check_value("halted after reset", 32'd0, 32'(halted));
		wait (halted === 1'b1);                     // watchdog covers a lost halt
		repeat (8) @(posedge clock);                // let the pipeline drain
		#2;
		check_value("halted stays high", 32'd1, 32'(halted));
		if (expected_regs.size() == 0 && expected_stores.size() == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			report_failure($sformatf("%0d register writes and %0d stores never appeared",
				expected_regs.size(), expected_stores.size()));
	end

	// run budget scales with program length
	initial
	begin
		wait (run_started === 1'b1);
		#((program_words.size() + 40) * clock_period);
		report_failure("timeout, the core did not halt and drain in time");
	end

endmodule

// ==== testbench/cpu_props.sv ====
// bound assertions on reset state, sticky halt and known write-back data
`timescale 1ns/1ps

module cpu_props import cpu_pkg::*; (
	input logic  clock,
	input logic  reset,
	input logic  reg_write,
	input logic  mem_write,
	input logic  halted,
	input word_t reg_write_data
);

	// strobes and halt are low one cycle into reset
	reset_clears: assert property (@(posedge clock)
		reset |=> (!reg_write && !mem_write && !halted))
		else $error("write strobe or halted high after a reset cycle");

	halt_sticky: assert property (@(posedge clock) (halted && !reset) |=> halted)
		else $error("halted fell without a reset");

	write_data_known: assert property (@(posedge clock)
		reg_write |-> !$isunknown(reg_write_data))
		else $error("reg_write_data has unknown bits during a register write");

endmodule

bind cpu_top cpu_props u_props (
	.clock(clock),
	.reset(reset),
	.reg_write(reg_write),
	.mem_write(mem_write),
	.halted(halted),
	.reg_write_data(reg_write_data)
);

// ==== src/cpu_top.sv ====
// top level of the five-stage pipelined core
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter int imem_addr_width = 8               // program space 4 to 8 bits
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       load_en,
	input  logic [imem_addr_width-1:0] load_addr,
	input  word_t                      load_data,
	output logic                       reg_write,
	output reg_addr_t                  reg_write_address,
	output word_t                      reg_write_data,
	output logic                       mem_write,
	output mem_addr_t                  mem_write_address,
	output word_t                      mem_write_data,
	output logic                       zero_flag,
	output logic                       negative_flag,
	output logic                       halted
);

	word_t instruction;                             // fetch to decode
	logic instruction_valid;
	reg_addr_t read_address_1;
	reg_addr_t read_address_2;
	word_t read_data_1;
	word_t read_data_2;
	mem_addr_t mem_read_address;
	word_t mem_read_data;
	logic ex_valid;                                 // decode/execute register
	alu_op_t ex_alu_op;
	result_sel_t ex_result_sel;
	word_t ex_operand_1;
	word_t ex_operand_2;
	word_t ex_value;
	logic ex_reg_write;
	logic ex_mem_write;
	reg_addr_t ex_dest;
	mem_addr_t ex_mem_address;

	fetch_unit #(.imem_addr_width(imem_addr_width)) u_fetch (
		.clock(clock), .reset(reset),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.instruction(instruction), .instruction_valid(instruction_valid),
		.halted(halted)
	);

	decode_control u_decode (
		.clock(clock), .reset(reset),
		.instruction(instruction), .instruction_valid(instruction_valid),
		.read_address_1(read_address_1), .read_address_2(read_address_2),
		.read_data_1(read_data_1), .read_data_2(read_data_2),
		.mem_read_address(mem_read_address), .mem_read_data(mem_read_data),
		.ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_result_sel(ex_result_sel),
		.ex_operand_1(ex_operand_1), .ex_operand_2(ex_operand_2), .ex_value(ex_value),
		.ex_reg_write(ex_reg_write), .ex_mem_write(ex_mem_write),
		.ex_dest(ex_dest), .ex_mem_address(ex_mem_address)
	);

	register_file u_regs (
		.clock(clock),
		.read_address_1(read_address_1), .read_address_2(read_address_2),
		.read_data_1(read_data_1), .read_data_2(read_data_2),
		.write_enable(reg_write), .write_address(reg_write_address),
		.write_data(reg_write_data)
	);

	data_memory u_dmem (
		.clock(clock),
		.read_address(mem_read_address), .read_data(mem_read_data),
		.write_enable(mem_write), .write_address(mem_write_address),
		.write_data(mem_write_data)
	);

	execute_unit u_execute (
		.clock(clock), .reset(reset),
		.ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_result_sel(ex_result_sel),
		.ex_operand_1(ex_operand_1), .ex_operand_2(ex_operand_2), .ex_value(ex_value),
		.ex_reg_write(ex_reg_write), .ex_mem_write(ex_mem_write),
		.ex_dest(ex_dest), .ex_mem_address(ex_mem_address),
		.mem_write(mem_write), .mem_write_address(mem_write_address),
		.mem_write_data(mem_write_data),
		.reg_write(reg_write), .reg_write_address(reg_write_address),
		.reg_write_data(reg_write_data),
		.zero_flag(zero_flag), .negative_flag(negative_flag)
	);

endmodule

// ==== src/execute_unit.sv ====
// alu, result select, flags, execute/memory and memory/write-back registers
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        ex_valid,
	input  alu_op_t     ex_alu_op,
	input  result_sel_t ex_result_sel,
	input  word_t       ex_operand_1,
	input  word_t       ex_operand_2,
	input  word_t       ex_value,
	input  logic        ex_reg_write,
	input  logic        ex_mem_write,
	input  reg_addr_t   ex_dest,
	input  mem_addr_t   ex_mem_address,
	output logic        mem_write,
	output mem_addr_t   mem_write_address,
	output word_t       mem_write_data,
	output logic        reg_write,
	output reg_addr_t   reg_write_address,
	output word_t       reg_write_data,
	output logic        zero_flag,
	output logic        negative_flag
);

	word_t alu_result;
	word_t result;
	logic result_zero;
	logic result_negative;
	logic mem_reg_write;                            // memory stage copies
	reg_addr_t mem_dest;
	word_t mem_result;
	logic mem_zero;
	logic mem_negative;

	always_comb
	begin
		case (ex_alu_op)
			alu_and:     alu_result = ex_operand_1 & ex_operand_2;
			alu_or:      alu_result = ex_operand_1 | ex_operand_2;
			alu_xor:     alu_result = ex_operand_1 ^ ex_operand_2;
			alu_not:     alu_result = ~ex_operand_1;
			alu_shl:     alu_result = ex_operand_1 << ex_operand_2;
			alu_shr_log: alu_result = ex_operand_1 >> ex_operand_2;
			alu_shr_ari: alu_result = word_t'($signed(ex_operand_1) >>> ex_operand_2);
			alu_add:     alu_result = ex_operand_1 + ex_operand_2; // wraps
			alu_sub:     alu_result = ex_operand_1 - ex_operand_2;
			default:     alu_result = ex_operand_1;               // pass
		endcase
	end

	// ldm data and immediates both arrive through ex_value
	assign result = (ex_result_sel == res_alu) ? alu_result : ex_value;
	assign result_zero = (result == '0);
	assign result_negative = result[data_width-1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
			reg_write <= 1'b0;
		end
		else
		begin
			mem_write <= ex_valid && ex_mem_write;  // store strobe
			mem_reg_write <= ex_valid && ex_reg_write;
			reg_write <= mem_reg_write;             // write-back strobe
		end
	end

	always_ff @(posedge clock)
	begin
		mem_write_address <= ex_mem_address;
		mem_write_data <= ex_value;                 // store source register
		mem_dest <= ex_dest;
		mem_result <= result;
		mem_zero <= result_zero;
		mem_negative <= result_negative;
		reg_write_address <= mem_dest;
		reg_write_data <= mem_result;
		zero_flag <= mem_zero;                      // tracks reg_write_data
		negative_flag <= mem_negative;
	end

endmodule

// ==== src/data_memory.sv ====
// 256-word data memory, async read and write on the rising edge
`timescale 1ns/1ps

module data_memory import cpu_pkg::*; (
	input  logic      clock,
	input  mem_addr_t read_address,
	output word_t     read_data,
	input  logic      write_enable,
	input  mem_addr_t write_address,
	input  word_t     write_data
);

	word_t mem [256];                               // contents undefined until stored

	assign read_data = mem[read_address];          // no bypass, store lands first

	always_ff @(posedge clock)
	begin
		if (write_enable)
			mem[write_address] <= write_data;
	end

endmodule

// ==== src/register_file.sv ====
// sixteen-entry register file, two async read ports, one write port with bypass
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic      clock,
	input  reg_addr_t read_address_1,
	input  reg_addr_t read_address_2,
	output word_t     read_data_1,
	output word_t     read_data_2,
	input  logic      write_enable,
	input  reg_addr_t write_address,
	input  word_t     write_data
);

	word_t regs [16];                               // no reset

	// write-first so a same-cycle read sees the new value
	assign read_data_1 = (write_enable && (write_address == read_address_1)) ?
		write_data : regs[read_address_1];
	assign read_data_2 = (write_enable && (write_address == read_address_2)) ?
		write_data : regs[read_address_2];

	always_ff @(posedge clock)
	begin
		if (write_enable)
			regs[write_address] <= write_data;
	end

endmodule

// ==== src/decode_control.sv ====
// instruction decode, operand capture and decode/execute stage register
`timescale 1ns/1ps

module decode_control import cpu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  word_t       instruction,
	input  logic        instruction_valid,
	output reg_addr_t   read_address_1,
	output reg_addr_t   read_address_2,
	input  word_t       read_data_1,
	input  word_t       read_data_2,
	output mem_addr_t   mem_read_address,
	input  word_t       mem_read_data,
	output logic        ex_valid,
	output alu_op_t     ex_alu_op,
	output result_sel_t ex_result_sel,
	output word_t       ex_operand_1,
	output word_t       ex_operand_2,
	output word_t       ex_value,
	output logic        ex_reg_write,
	output logic        ex_mem_write,
	output reg_addr_t   ex_dest,
	output mem_addr_t   ex_mem_address
);

	opcode_t opcode;
	alu_op_t alu_op;
	result_sel_t result_sel;
	word_t operand_2;
	word_t value;
	logic reg_we;
	logic mem_we;

	assign opcode = instruction[15:12];
	// stm reads its store source from the dest field
	assign read_address_1 = (opcode == op_stm) ? instruction[11:8] : instruction[7:4];
	assign read_address_2 = instruction[3:0];
	assign mem_read_address = instruction[7:0];     // ldm address

	always_comb
	begin
		alu_op = alu_pass;
		result_sel = res_alu;
		operand_2 = read_data_2;
		value = read_data_1;
		reg_we = 1'b0;
		mem_we = 1'b0;
		case (opcode)
			op_ldm:
			begin
				reg_we = 1'b1;
				result_sel = res_mem;
				value = mem_read_data;                // captured here, no later read
			end
			op_stm:  mem_we = 1'b1;                   // value is store data
			op_ldr:
			begin
				reg_we = 1'b1;
				result_sel = res_value;
				value = {{(data_width-8){1'b0}}, instruction[7:0]}; // zero extend
			end
			op_mov:
			begin
				reg_we = 1'b1;
				result_sel = res_value;
			end
			op_and:  {reg_we, alu_op} = {1'b1, alu_and};
			op_or:   {reg_we, alu_op} = {1'b1, alu_or};
			op_xor:  {reg_we, alu_op} = {1'b1, alu_xor};
			op_not:  {reg_we, alu_op} = {1'b1, alu_not};
			op_shl, op_shr:
			begin
				reg_we = 1'b1;
				operand_2 = {{(data_width-3){1'b0}}, instruction[2:0]}; // shift amount
				if (opcode == op_shl)
					alu_op = alu_shl;                   // arith left same as logical
				else
					alu_op = instruction[3] ? alu_shr_ari : alu_shr_log;
			end
			op_add:  {reg_we, alu_op} = {1'b1, alu_add};
			op_sub:  {reg_we, alu_op} = {1'b1, alu_sub};
			op_nop, op_halt: ;                        // no writes
			default: ;                                // old div class acts as nop
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex_valid <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_write <= 1'b0;
		end
		else
		begin
			ex_valid <= instruction_valid;          // empty slot clears valid
			ex_reg_write <= reg_we;
			ex_mem_write <= mem_we;
		end
	end

	always_ff @(posedge clock)
	begin
		ex_alu_op <= alu_op;
		ex_result_sel <= result_sel;
		ex_operand_1 <= read_data_1;
		ex_operand_2 <= operand_2;
		ex_value <= value;
		ex_dest <= instruction[11:8];
		ex_mem_address <= instruction[7:0];       // stm target
	end

endmodule

// ==== src/fetch_unit.sv ====
// program counter, loadable instruction memory, halt detect, fetch/decode register
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
	parameter int imem_addr_width = 8               // pc width, memory depth 2**width
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       load_en,        // program load strobe
	input  logic [imem_addr_width-1:0] load_addr,
	input  word_t                      load_data,
	output word_t                      instruction,    // fetch/decode register
	output logic                       instruction_valid,
	output logic                       halted
);

	word_t imem [2**imem_addr_width];               // instruction store, no reset
	logic [imem_addr_width-1:0] pc;
	word_t fetch_word;
	logic fetch_halt;

	assign fetch_word = imem[pc];                   // async read at pc
	assign fetch_halt = (fetch_word[15:12] == op_halt);

	// program load port
	always_ff @(posedge clock)
	begin
		if (load_en)
			imem[load_addr] <= load_data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= '0;
			halted <= 1'b0;
			instruction_valid <= 1'b0;
		end
		else
		begin
			if (!halted && !fetch_halt)
				pc <= pc + imem_addr_width'(1);       // freeze on halt
			if (fetch_halt)
				halted <= 1'b1;                       // sticky until reset
			instruction_valid <= !halted && !fetch_halt; // halt word never valid
		end
	end

	always_ff @(posedge clock)
	begin
		instruction <= fetch_word;                  // payload only
	end

endmodule

// ==== src/cpu_pkg.sv ====
// word and address types, opcode constants, alu operation and result select enums
package cpu_pkg;

	localparam int data_width = 16;                 // register, memory word and alu width

	typedef logic [data_width-1:0] word_t;          // one data or instruction word
	typedef logic [3:0] reg_addr_t;                 // register index, sixteen registers
	typedef logic [7:0] mem_addr_t;                 // data memory address, 256 words

	// instruction opcode in bits 15..12
	typedef logic [3:0] opcode_t;

	localparam opcode_t op_ldm  = 4'b0000;          // load reg from memory
	localparam opcode_t op_stm  = 4'b0001;          // store reg to memory
	localparam opcode_t op_ldr  = 4'b0010;          // load 8-bit immediate
	localparam opcode_t op_mov  = 4'b0011;          // reg to reg copy
	localparam opcode_t op_and  = 4'b0100;
	localparam opcode_t op_or   = 4'b0101;
	localparam opcode_t op_xor  = 4'b0110;
	localparam opcode_t op_not  = 4'b0111;
	localparam opcode_t op_shl  = 4'b1000;          // kind in bit 3, amount in 2..0
	localparam opcode_t op_shr  = 4'b1001;
	localparam opcode_t op_add  = 4'b1010;
	localparam opcode_t op_sub  = 4'b1011;
	localparam opcode_t op_nop  = 4'b1110;          // 1100 and 1101 also behave as nop
	localparam opcode_t op_halt = 4'b1111;          // stops fetch

	typedef enum logic [3:0] {
		alu_and,
		alu_or,
		alu_xor,
		alu_not,
		alu_shl,                                      // zero fill
		alu_shr_log,                                  // zero fill
		alu_shr_ari,                                  // sign fill
		alu_add,
		alu_sub,
		alu_pass                                      // first operand through
	} alu_op_t;

	// write-back source
	typedef enum logic [1:0] {
		res_alu,                                      // alu result
		res_value,                                    // immediate or moved register
		res_mem                                       // data memory word
	} result_sel_t;

endpackage
